//--- verilog/ifu_pkg.sv
package ifu_pkg;

  // Instruction and bus data width
  localparam int INST_W = 32;

  // Fetch PC after reset
  localparam logic [31:0] PC_INIT = 32'h8000_0000;

  // RISC-V major opcodes that redirect control flow
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // Refill sequence of the instruction cache
  //   IDLE  : lookup only, a miss starts a refill
  //   BEAT0 : request the first word of the line
  //   BEAT1 : request the second word of the line
  //   FILL  : write the captured line into the arrays
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    BEAT0 = 2'd1,
    BEAT1 = 2'd2,
    FILL  = 2'd3
  } l1i_state_e;

endpackage

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl #(
  parameter int ADDR_W = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       hit_i,
  input  logic [ifu_pkg::INST_W-1:0] hit_inst_i,
  input  logic                       fill_busy_i,
  input  logic                       pred_taken_i,
  input  logic [ADDR_W-1:0]          pred_target_i,
  input  logic                       redirect_i,
  input  logic [ADDR_W-1:0]          redirect_pc_i,
  input  logic                       next_ready_i,
  output logic [ADDR_W-1:0]          fetch_pc_o,
  output logic                       valid_o,
  output logic [ifu_pkg::INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0]          pc_o,
  output logic                       pred_taken_o,
  output logic                       ready_o
);

  logic [ADDR_W-1:0]          pc_q;
  logic                       hold_q;
  logic [ifu_pkg::INST_W-1:0] hold_inst_q;
  logic                       hold_taken_q;
  logic [ADDR_W-1:0]          hold_target_q;
  logic                       redirect_take;
  logic                       xfer;
  logic [ADDR_W-1:0]          target;

  // Redirects are refused only while the cache writes a line
  assign ready_o       = !fill_busy_i;
  assign redirect_take = redirect_i && ready_o;

  // A stalled instruction is replayed from the hold registers
  assign valid_o      = (hit_i || hold_q) && !redirect_take;
  assign inst_o       = hold_q ? hold_inst_q : hit_inst_i;
  assign pred_taken_o = valid_o && (hold_q ? hold_taken_q : pred_taken_i);
  assign target       = hold_q ? hold_target_q : pred_target_i;
  assign pc_o         = pc_q;
  assign fetch_pc_o   = pc_q;
  assign xfer         = valid_o && next_ready_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q   <= ADDR_W'(ifu_pkg::PC_INIT);
      hold_q <= 1'b0;
    end else begin
      if (redirect_take) begin
        pc_q <= redirect_pc_i;
      end else if (xfer) begin
        pc_q <= pred_taken_o ? target : pc_q + ADDR_W'(4);
      end
      hold_q <= valid_o && !next_ready_i;
    end
  end

  // Capture what decode sees on the first stalled cycle
  always_ff @(posedge clk) begin
    if (valid_o && !next_ready_i) begin
      hold_inst_q   <= inst_o;
      hold_taken_q  <= pred_taken_o;
      hold_target_q <= target;
    end
  end

endmodule

//--- verilog/l1i_cache.sv
`timescale 1ns/1ns

module l1i_cache #(
  parameter int ADDR_W        = 32,
  parameter int L1I_SETS_LOG2 = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [ADDR_W-1:0]          fetch_pc_i,
  input  logic [ifu_pkg::INST_W-1:0] ifu_rdata_i,
  input  logic                       ifu_rvalid_i,
  output logic                       ifu_arvalid_o,
  output logic [ADDR_W-1:0]          ifu_araddr_o,
  output logic                       hit_o,
  output logic [ifu_pkg::INST_W-1:0] hit_inst_o,
  output logic                       fill_busy_o
);

  localparam int SETS   = 1 << L1I_SETS_LOG2;
  // Bit 2 picks the word in a line, the set index sits just above it
  localparam int IDX_LO = 3;
  localparam int TAG_LO = IDX_LO + L1I_SETS_LOG2;
  localparam int TAG_W  = ADDR_W - TAG_LO;

  logic [ifu_pkg::INST_W-1:0] data_q [SETS][2];
  logic [TAG_W-1:0]           tag_q  [SETS];
  logic [SETS-1:0]            valid_q;

  ifu_pkg::l1i_state_e        state_q;
  logic [ADDR_W-1:IDX_LO]     line_q;
  logic [ifu_pkg::INST_W-1:0] beat0_q;
  logic [ifu_pkg::INST_W-1:0] beat1_q;

  logic [L1I_SETS_LOG2-1:0]   pc_idx;
  logic [TAG_W-1:0]           pc_tag;
  logic [L1I_SETS_LOG2-1:0]   fill_idx;

  assign pc_idx   = fetch_pc_i[TAG_LO-1:IDX_LO];
  assign pc_tag   = fetch_pc_i[ADDR_W-1:TAG_LO];
  assign fill_idx = line_q[TAG_LO-1:IDX_LO];

  // Combinational lookup on the current fetch PC
  assign hit_o      = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_inst_o = data_q[pc_idx][fetch_pc_i[2]];

  // Read bus, one request per beat at base then base plus 4
  assign ifu_arvalid_o = (state_q == ifu_pkg::BEAT0) || (state_q == ifu_pkg::BEAT1);
  assign ifu_araddr_o  = {line_q, (state_q == ifu_pkg::BEAT1), 2'b00};
  assign fill_busy_o   = (state_q == ifu_pkg::FILL);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ifu_pkg::IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        ifu_pkg::IDLE: begin
          if (!hit_o) begin
            state_q <= ifu_pkg::BEAT0;
          end
        end
        ifu_pkg::BEAT0: begin
          if (ifu_rvalid_i) begin
            state_q <= ifu_pkg::BEAT1;
          end
        end
        ifu_pkg::BEAT1: begin
          if (ifu_rvalid_i) begin
            state_q <= ifu_pkg::FILL;
          end
        end
        ifu_pkg::FILL: begin
          valid_q[fill_idx] <= 1'b1;
          state_q           <= ifu_pkg::IDLE;
        end
        default: state_q <= ifu_pkg::IDLE;
      endcase
    end
  end

  // Line address and beat data, written into the arrays only in FILL
  always_ff @(posedge clk) begin
    if (state_q == ifu_pkg::IDLE && !hit_o) begin
      line_q <= fetch_pc_i[ADDR_W-1:IDX_LO];
    end
    if (state_q == ifu_pkg::BEAT0 && ifu_rvalid_i) begin
      beat0_q <= ifu_rdata_i;
    end
    if (state_q == ifu_pkg::BEAT1 && ifu_rvalid_i) begin
      beat1_q <= ifu_rdata_i;
    end
    if (state_q == ifu_pkg::FILL) begin
      data_q[fill_idx][0] <= beat0_q;
      data_q[fill_idx][1] <= beat1_q;
      tag_q[fill_idx]     <= line_q[ADDR_W-1:TAG_LO];
    end
  end

endmodule

//--- verilog/bpu.sv
`timescale 1ns/1ns

module bpu #(
  parameter int ADDR_W        = 32,
  parameter int BTB_SETS_LOG2 = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [ADDR_W-1:0]          fetch_pc_i,
  input  logic [ifu_pkg::INST_W-1:0] inst_i,
  input  logic                       resolve_valid_i,
  input  logic [ADDR_W-1:0]          resolve_pc_i,
  input  logic                       resolve_taken_i,
  input  logic [ADDR_W-1:0]          resolve_target_i,
  output logic                       pred_taken_o,
  output logic [ADDR_W-1:0]          pred_target_o
);

  localparam int ENTRIES = 1 << BTB_SETS_LOG2;
  localparam int TAG_LO  = 2 + BTB_SETS_LOG2;
  localparam int TAG_W   = ADDR_W - TAG_LO;

  logic [TAG_W-1:0]         tag_q    [ENTRIES];
  logic [ADDR_W-1:0]        target_q [ENTRIES];
  logic [ENTRIES-1:0]       valid_q;

  logic [BTB_SETS_LOG2-1:0] look_idx;
  logic [TAG_W-1:0]         look_tag;
  logic [BTB_SETS_LOG2-1:0] upd_idx;
  logic [TAG_W-1:0]         upd_tag;
  logic                     is_cti;
  logic                     upd_match;

  assign look_idx = fetch_pc_i[TAG_LO-1:2];
  assign look_tag = fetch_pc_i[ADDR_W-1:TAG_LO];
  assign upd_idx  = resolve_pc_i[TAG_LO-1:2];
  assign upd_tag  = resolve_pc_i[ADDR_W-1:TAG_LO];

  // Only control-transfer opcodes may use a buffer hit
  always_comb begin
    case (inst_i[6:0])
      ifu_pkg::OP_JAL,
      ifu_pkg::OP_JALR,
      ifu_pkg::OP_BRANCH,
      ifu_pkg::OP_SYSTEM: is_cti = 1'b1;
      default:            is_cti = 1'b0;
    endcase
  end

  // No direction state, a hit on such an opcode counts as taken
  assign pred_taken_o  = valid_q[look_idx] && (tag_q[look_idx] == look_tag) && is_cti;
  assign pred_target_o = target_q[look_idx];

  assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
    end else if (resolve_valid_i) begin
      if (resolve_taken_i) begin
        valid_q[upd_idx] <= 1'b1;
      end else if (upd_match) begin
        // Not taken, so drop the stale entry
        valid_q[upd_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resolve_valid_i && resolve_taken_i) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= resolve_target_i;
    end
  end

endmodule

//--- verilog/ifu_top.sv
`timescale 1ns/1ns

module ifu_top #(
  parameter int ADDR_W        = 32,
  parameter int L1I_SETS_LOG2 = 2,
  parameter int BTB_SETS_LOG2 = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  // Read bus toward memory
  output logic                       ifu_arvalid_o,
  output logic [ADDR_W-1:0]          ifu_araddr_o,
  input  logic [ifu_pkg::INST_W-1:0] ifu_rdata_i,
  input  logic                       ifu_rvalid_i,
  // Decode side
  output logic                       valid_o,
  output logic [ifu_pkg::INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0]          pc_o,
  output logic                       pred_taken_o,
  input  logic                       next_ready_i,
  output logic                       ready_o,
  // Backend side
  input  logic                       redirect_i,
  input  logic [ADDR_W-1:0]          redirect_pc_i,
  input  logic                       resolve_valid_i,
  input  logic [ADDR_W-1:0]          resolve_pc_i,
  input  logic                       resolve_taken_i,
  input  logic [ADDR_W-1:0]          resolve_target_i
);

  logic [ADDR_W-1:0]          fetch_pc;
  logic                       hit;
  logic [ifu_pkg::INST_W-1:0] hit_inst;
  logic                       fill_busy;
  logic                       pred_taken;
  logic [ADDR_W-1:0]          pred_target;

  fetch_ctrl #(
    .ADDR_W(ADDR_W)
  ) u_fetch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .hit_i         (hit),
    .hit_inst_i    (hit_inst),
    .fill_busy_i   (fill_busy),
    .pred_taken_i  (pred_taken),
    .pred_target_i (pred_target),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .next_ready_i  (next_ready_i),
    .fetch_pc_o    (fetch_pc),
    .valid_o       (valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .pred_taken_o  (pred_taken_o),
    .ready_o       (ready_o)
  );

  l1i_cache #(
    .ADDR_W        (ADDR_W),
    .L1I_SETS_LOG2 (L1I_SETS_LOG2)
  ) u_l1i_cache (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc_i    (fetch_pc),
    .ifu_rdata_i   (ifu_rdata_i),
    .ifu_rvalid_i  (ifu_rvalid_i),
    .ifu_arvalid_o (ifu_arvalid_o),
    .ifu_araddr_o  (ifu_araddr_o),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .fill_busy_o   (fill_busy)
  );

  bpu #(
    .ADDR_W        (ADDR_W),
    .BTB_SETS_LOG2 (BTB_SETS_LOG2)
  ) u_bpu (
    .clk              (clk),
    .rst              (rst),
    .fetch_pc_i       (fetch_pc),
    .inst_i           (hit_inst),
    .resolve_valid_i  (resolve_valid_i),
    .resolve_pc_i     (resolve_pc_i),
    .resolve_taken_i  (resolve_taken_i),
    .resolve_target_i (resolve_target_i),
    .pred_taken_o     (pred_taken),
    .pred_target_o    (pred_target)
  );

endmodule

//--- tb/imem_model.sv
`timescale 1ns/1ns

module imem_model #(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              arvalid_i,
  input  logic [ADDR_W-1:0] araddr_i,
  output logic              rvalid_o,
  output logic [31:0]       rdata_o
);

  // Cycles still to wait before the current beat, -1 when no beat is pending
  int wait_left;

  // JAL at words whose address bits 5:3 are 5, a plain ALU op elsewhere
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [6:0] op;
    op = (addr[5:3] == 3'd5) ? 7'(ifu_pkg::OP_JAL) : 7'h13;
    return {addr[25:2], 1'b0, op};
  endfunction

  initial begin
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    wait_left = -1;
  end

  // Beats are answered on the falling edge, one cycle wide
  always @(negedge clk) begin
    if (rst) begin
      rvalid_o  <= 1'b0;
      wait_left = -1;
    end else if (rvalid_o) begin
      rvalid_o  <= 1'b0;
      wait_left = -1;
    end else if (arvalid_i) begin
      if (wait_left < 0) begin
        wait_left = int'($urandom_range(3, 0));
      end
      if (wait_left == 0) begin
        rvalid_o  <= 1'b1;
        rdata_o   <= word_at(32'(araddr_i));
        wait_left = -1;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

endmodule

//--- tb/tb_ifu.sv
`timescale 1ns/1ns

module tb_ifu;

  localparam int MAX_CYCLES   = 4000;
  localparam int NUM_XFERS    = 300;
  localparam int MIN_EVENTS   = 10;
  localparam int WINDOW_WORDS = 64;

  logic        clk;
  logic        rst;
  logic        ifu_arvalid;
  logic [31:0] ifu_araddr;
  logic [31:0] ifu_rdata;
  logic        ifu_rvalid;
  logic        valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        pred_taken;
  logic        next_ready;
  logic        ready;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        resolve_valid;
  logic [31:0] resolve_pc;
  logic        resolve_taken;
  logic [31:0] resolve_target;

  // Reference models of the cache lines and of the branch target buffer
  int          l1i_log2;
  int          btb_log2;
  logic        l1i_valid [64];
  logic [31:0] l1i_line  [64];
  logic        btb_valid [64];
  logic [31:0] btb_pc    [64];
  logic [31:0] btb_target[64];

  int          cycles;
  int          xfers;
  int          redirects;
  int          taken_resolves;
  logic [31:0] exp_pc;
  logic        in_req;
  logic        beat;
  logic [31:0] req_base;
  logic        fill_q;
  logic        stall_q;
  logic [31:0] stall_pc;
  logic [31:0] stall_inst;
  logic        stall_taken;
  logic        pred_held;
  logic        held_taken;
  logic [31:0] held_target;

  ifu_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .ifu_arvalid_o    (ifu_arvalid),
    .ifu_araddr_o     (ifu_araddr),
    .ifu_rdata_i      (ifu_rdata),
    .ifu_rvalid_i     (ifu_rvalid),
    .valid_o          (valid),
    .inst_o           (inst),
    .pc_o             (pc),
    .pred_taken_o     (pred_taken),
    .next_ready_i     (next_ready),
    .ready_o          (ready),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .resolve_valid_i  (resolve_valid),
    .resolve_pc_i     (resolve_pc),
    .resolve_taken_i  (resolve_taken),
    .resolve_target_i (resolve_target)
  );

  imem_model mem0 (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (ifu_arvalid),
    .araddr_i  (ifu_araddr),
    .rvalid_o  (ifu_rvalid),
    .rdata_o   (ifu_rdata)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [6:0] op;
    op = (addr[5:3] == 3'd5) ? 7'(ifu_pkg::OP_JAL) : 7'h13;
    return {addr[25:2], 1'b0, op};
  endfunction

  function automatic logic is_cti(input logic [6:0] op);
    return (op == ifu_pkg::OP_JAL) || (op == ifu_pkg::OP_JALR) ||
           (op == ifu_pkg::OP_BRANCH) || (op == ifu_pkg::OP_SYSTEM);
  endfunction

  function automatic int btb_index(input logic [31:0] addr);
    return int'((addr >> 2) & ((32'd1 << btb_log2) - 32'd1));
  endfunction

  function automatic int line_index(input logic [31:0] addr);
    return int'((addr >> 3) & ((32'd1 << l1i_log2) - 32'd1));
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // Each request starts aligned, on a line not yet cached, and steps base then base plus 4
  task automatic check_bus();
    int idx;
    idx = line_index(ifu_araddr);
    // Redirects are refused only in the fill cycle after the second beat
    assert (ready == !fill_q)
    else fail_run($sformatf("** Error %0t: ready %b, expected %b", $time, ready, !fill_q));
    fill_q = 1'b0;
    if (ifu_arvalid && !in_req) begin
      assert (ifu_araddr[2:0] == 3'b000 && !(l1i_valid[idx] && l1i_line[idx] == ifu_araddr >> 3))
      else fail_run($sformatf("** Error %0t: bad refill request at %h", $time, ifu_araddr));
      in_req   = 1'b1;
      beat     = 1'b0;
      req_base = ifu_araddr;
    end
    if (ifu_arvalid) begin
      assert (ifu_araddr == req_base + (beat ? 32'd4 : 32'd0))
      else fail_run($sformatf("** Error %0t: beat address %h, base %h", $time, ifu_araddr,
                              req_base));
    end
    if (ifu_rvalid && in_req) begin
      if (beat) begin
        idx            = line_index(req_base);
        l1i_valid[idx] = 1'b1;
        l1i_line[idx]  = req_base >> 3;
        in_req         = 1'b0;
        fill_q         = 1'b1;
      end
      beat = ~beat;
    end
  endtask

  task automatic check_stall();
    if (stall_q && valid) begin
      assert (pc == stall_pc && inst == stall_inst && pred_taken == stall_taken)
      else fail_run($sformatf("** Error %0t: decode outputs changed while stalled", $time));
    end
    stall_q     = valid && !next_ready;
    stall_pc    = pc;
    stall_inst  = inst;
    stall_taken = pred_taken;
  endtask

  task automatic check_transfer();
    logic [31:0] word;
    logic        exp_taken;
    logic [31:0] exp_target;
    int          idx;
    word       = mem_word(pc);
    idx        = btb_index(pc);
    exp_taken  = btb_valid[idx] && btb_pc[idx] == pc && is_cti(word[6:0]);
    exp_target = btb_target[idx];
    // A stalled instruction keeps the prediction it had when the stall began
    if (pred_held) begin
      exp_taken  = held_taken;
      exp_target = held_target;
    end
    if (redirect && ready) begin
      assert (!valid)
      else fail_run($sformatf("** Error %0t: valid high in a redirect cycle", $time));
      exp_pc    = redirect_pc;
      redirects = redirects + 1;
      pred_held = 1'b0;
    end else if (valid && next_ready) begin
      if (xfers == 0 && redirects == 0) begin
        assert (pc == ifu_pkg::PC_INIT)
        else fail_run($sformatf("** Error %0t: first pc %h", $time, pc));
      end
      assert (pc == exp_pc)
      else fail_run($sformatf("** Error %0t: pc %h, expected %h", $time, pc, exp_pc));
      assert (inst == word)
      else fail_run($sformatf("** Error %0t: inst %h, expected %h", $time, inst, word));
      assert (pred_taken == exp_taken)
      else fail_run($sformatf("** Error %0t: pred_taken %b at pc %h", $time, pred_taken, pc));
      exp_pc    = exp_taken ? exp_target : pc + 32'd4;
      xfers     = xfers + 1;
      pred_held = 1'b0;
    end else if (valid) begin
      held_taken  = exp_taken;
      held_target = exp_target;
      pred_held   = 1'b1;
    end
  endtask

  task automatic update_btb();
    int idx;
    idx = btb_index(resolve_pc);
    if (resolve_valid && resolve_taken) begin
      btb_valid[idx]  = 1'b1;
      btb_pc[idx]     = resolve_pc;
      btb_target[idx] = resolve_target;
      taken_resolves  = taken_resolves + 1;
    end else if (resolve_valid && btb_pc[idx] == resolve_pc) begin
      btb_valid[idx] = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      assert (!ifu_arvalid && !valid)
      else fail_run($sformatf("** Error %0t: bus or valid active in reset", $time));
    end else if (cycles >= MAX_CYCLES) begin
      fail_run("Timeout: the run did not finish its transfers within the cycle limit");
    end else begin
      cycles = cycles + 1;
      check_bus();
      check_stall();
      check_transfer();
      update_btb();
    end
  end

  task automatic drive_stimulus();
    next_ready     = ($urandom_range(3, 0) != 0);
    redirect       = ($urandom_range(29, 0) == 0);
    redirect_pc    = ifu_pkg::PC_INIT + ($urandom_range(WINDOW_WORDS - 1, 0) << 2);
    resolve_valid  = ($urandom_range(7, 0) == 0);
    resolve_taken  = ($urandom_range(3, 0) != 0);
    // Mostly the JAL words of the window, now and then any word
    if ($urandom_range(3, 0) == 0) begin
      resolve_pc = ifu_pkg::PC_INIT + ($urandom_range(WINDOW_WORDS - 1, 0) << 2);
    end else begin
      resolve_pc = ifu_pkg::PC_INIT + ($urandom_range(3, 0) << 6) + 32'h28 +
                   ($urandom_range(1, 0) << 2);
    end
    resolve_target = ifu_pkg::PC_INIT + ($urandom_range(WINDOW_WORDS - 1, 0) << 2);
  endtask

  initial begin
    void'($urandom(75));
    rst            = 1'b1;
    next_ready     = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = '0;
    resolve_valid  = 1'b0;
    resolve_pc     = '0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    l1i_log2       = dut0.L1I_SETS_LOG2;
    btb_log2       = dut0.BTB_SETS_LOG2;
    for (int i = 0; i < 64; i++) begin
      l1i_valid[i] = 1'b0;
      l1i_line[i]  = '0;
      btb_valid[i] = 1'b0;
      btb_pc[i]    = '0;
      btb_target[i] = '0;
    end
    cycles         = 0;
    xfers          = 0;
    redirects      = 0;
    taken_resolves = 0;
    exp_pc         = ifu_pkg::PC_INIT;
    in_req         = 1'b0;
    beat           = 1'b0;
    req_base       = '0;
    fill_q         = 1'b0;
    stall_q        = 1'b0;
    pred_held      = 1'b0;
    held_taken     = 1'b0;
    held_target    = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (xfers < NUM_XFERS) begin
      @(negedge clk);
      drive_stimulus();
    end
    if (redirects >= MIN_EVENTS && taken_resolves >= MIN_EVENTS) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run("Run ended with too few redirects or taken resolves");
    end
  end

endmodule

//--- build.f
verilog/ifu_pkg.sv
verilog/fetch_ctrl.sv
verilog/l1i_cache.sv
verilog/bpu.sv
verilog/ifu_top.sv
tb/imem_model.sv
tb/tb_ifu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_ifu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
